// ==== include/fp16_config.svh ====
`ifndef FP16_CONFIG_SVH
`define FP16_CONFIG_SVH

// Half precision field widths
`define FP_EXP_W 5
`define FP_MAN_W 10

// Guard, round and sticky below the significand
`define FP_GRS_W 3

// Significand with hidden one, and with GRS appended
`define FP_SIG_W (`FP_MAN_W + 1)
`define FP_EXT_W (`FP_SIG_W + `FP_GRS_W)

// All-ones exponent, reserved for Inf/NaN
`define FP_EXP_MAX 31

// Canonical quiet NaN
`define FP_QNAN 16'h7E00

`endif

// ==== hw/fpAddPkg.sv ====
`include "fp16_config.svh"

package fpAddPkg;

	// IEEE half word
	typedef struct packed {
		logic                 sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_MAN_W-1:0] man;
	} fpWord_t;

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} fpOp_e;

	// Exception flags, no divide-by-zero for add/sub
	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpFlags_t;

	// Unpack -> align
	typedef struct packed {
		logic                 valid;
		logic                 special;  // Some operand had all-ones exponent
		logic                 effSub;   // Signs differ after op applied
		logic                 resSign;
		logic                 zeroSign; // Sign of an exact zero sum
		logic [`FP_EXP_W-1:0] bigExp;
		logic [`FP_SIG_W-1:0] bigSig;
		logic [`FP_SIG_W-1:0] smallSig;
		logic [4:0]           shiftAmt; // Exp difference, saturated
	} unpackOut_t;

	// Align -> normalize
	typedef struct packed {
		logic                 valid;
		logic                 special;
		logic                 effSub;
		logic                 resSign;
		logic                 zeroSign;
		logic [`FP_EXP_W-1:0] bigExp;
		logic [`FP_SIG_W-1:0] bigSig;
		logic [`FP_EXT_W-1:0] alignedSig; // Smaller sig plus GRS
	} alignOut_t;

	// Normalize -> round
	typedef struct packed {
		logic                        valid;
		logic                        special;
		logic                        resSign;
		logic                        zero;
		logic signed [`FP_EXP_W+1:0] normExp; // Can drop to zero or below
		logic [`FP_EXT_W-1:0]        normSig; // Leading one at MSB
	} normOut_t;

endpackage

// ==== hw/fpUnpack.sv ====
`timescale 1ns/1ps
`include "fp16_config.svh"

module fpUnpack
	import fpAddPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       inValid,
	input  fpWord_t    a,
	input  fpWord_t    b,
	input  fpOp_e      op,
	output unpackOut_t stage
);

	logic                           signA;
	logic                           signB;  // b sign after op applied
	logic [`FP_SIG_W-1:0]           sigA;
	logic [`FP_SIG_W-1:0]           sigB;
	logic [`FP_EXP_W+`FP_MAN_W-1:0] magA;
	logic [`FP_EXP_W+`FP_MAN_W-1:0] magB;
	logic                           aBig;   // a has the larger magnitude
	logic [`FP_EXP_W-1:0]           expDiff;

	assign signA = a.sign;
	assign signB = b.sign ^ (op == opSub); // Subtract is add of negated b

	// Zero exponent flushes to zero, hidden one otherwise
	assign sigA = (a.exp == '0) ? '0 : {1'b1, a.man};
	assign sigB = (b.exp == '0) ? '0 : {1'b1, b.man};

	// Magnitude order, flushed mantissa so subnormals count as zero
	assign magA = {a.exp, sigA[`FP_MAN_W-1:0]};
	assign magB = {b.exp, sigB[`FP_MAN_W-1:0]};
	assign aBig = (magA >= magB);

	assign expDiff = aBig ? (a.exp - b.exp) : (b.exp - a.exp); // Never negative

	always_ff @(posedge clk) begin
		if (rst) begin
			stage <= '0;
		end else begin
			stage.valid    <= inValid;
			stage.special  <= (a.exp == `FP_EXP_MAX) || (b.exp == `FP_EXP_MAX);
			stage.effSub   <= signA ^ signB;
			stage.resSign  <= aBig ? signA : signB;
			stage.zeroSign <= signA & signB; // -0 only for (-x) + (-y)
			stage.bigExp   <= aBig ? a.exp : b.exp;
			stage.bigSig   <= aBig ? sigA : sigB;
			stage.smallSig <= aBig ? sigB : sigA;
			// Past 15 the whole small sig is sticky anyway
			stage.shiftAmt <= (expDiff > 5'd15) ? 5'd15 : expDiff;
		end
	end

endmodule

// ==== hw/fpAlign.sv ====
`timescale 1ns/1ps
`include "fp16_config.svh"

module fpAlign
	import fpAddPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  unpackOut_t stage,
	output alignOut_t  aligned
);

	logic [`FP_EXT_W-1:0] ext;    // Small sig with empty GRS
	logic [`FP_EXT_W-1:0] lvl1;
	logic [`FP_EXT_W-1:0] lvl2;
	logic [3:0]           coarse; // 0, 4, 8 or 12
	logic [1:0]           fine;   // 0 to 3
	logic                 stick1;
	logic                 stick2;

	assign ext    = {stage.smallSig, {`FP_GRS_W{1'b0}}};
	assign coarse = {stage.shiftAmt[3:2], 2'b00};
	assign fine   = stage.shiftAmt[1:0];

	always_comb begin
		// First level, shifted-out bits collapse into bit 0
		stick1 = |(ext & ~({`FP_EXT_W{1'b1}} << coarse));
		lvl1   = (ext >> coarse) | {{(`FP_EXT_W-1){1'b0}}, stick1};
		// Second level, old sticky folds in again
		stick2 = |(lvl1 & ~({`FP_EXT_W{1'b1}} << fine));
		lvl2   = (lvl1 >> fine) | {{(`FP_EXT_W-1){1'b0}}, stick2};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			aligned <= '0;
		end else begin
			aligned.valid      <= stage.valid;
			aligned.special    <= stage.special;
			aligned.effSub     <= stage.effSub;
			aligned.resSign    <= stage.resSign;
			aligned.zeroSign   <= stage.zeroSign;
			aligned.bigExp     <= stage.bigExp;
			aligned.bigSig     <= stage.bigSig;
			aligned.alignedSig <= lvl2; // Bit 0 is sticky
		end
	end

endmodule

// ==== hw/fpNormalize.sv ====
`timescale 1ns/1ps
`include "fp16_config.svh"

module fpNormalize
	import fpAddPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  alignOut_t aligned,
	output normOut_t  norm
);

	logic [`FP_EXT_W-1:0]        bigExt;
	logic [`FP_EXT_W:0]          sum;     // Extra bit for add carry
	logic                        carry;
	logic                        sumZero;
	logic [3:0]                  lead;    // Left shift to bring one to MSB
	logic [`FP_EXT_W-1:0]        shifted;
	logic signed [`FP_EXP_W+1:0] expIn;

	assign bigExt = {aligned.bigSig, {`FP_GRS_W{1'b0}}};

	// Big >= small in magnitude, so the difference never goes negative
	assign sum = aligned.effSub ? ({1'b0, bigExt} - {1'b0, aligned.alignedSig})
	                            : ({1'b0, bigExt} + {1'b0, aligned.alignedSig});

	assign carry   = sum[`FP_EXT_W];
	assign sumZero = ~|sum;
	assign expIn   = $signed({2'b00, aligned.bigExp});

	// Priority search, highest set bit wins
	always_comb begin
		lead = '0;
		for (int i = 0; i < `FP_EXT_W; i++) begin
			if (sum[i])
				lead = 4'(`FP_EXT_W - 1 - i);
		end
		shifted = sum[`FP_EXT_W-1:0] << lead;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			norm <= '0;
		end else begin
			norm.valid   <= aligned.valid;
			norm.special <= aligned.special;
			norm.zero    <= sumZero;
			norm.resSign <= sumZero ? aligned.zeroSign : aligned.resSign;
			if (carry) begin
				// Carry out, one right with sticky kept
				norm.normSig <= {sum[`FP_EXT_W:2], sum[1] | sum[0]};
				norm.normExp <= expIn + 7'sd1;
			end else begin
				norm.normSig <= shifted;
				norm.normExp <= expIn - $signed({3'b000, lead}); // May hit zero or below
			end
		end
	end

endmodule

// ==== hw/fpRound.sv ====
`timescale 1ns/1ps
`include "fp16_config.svh"

module fpRound
	import fpAddPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  normOut_t norm,
	output logic     outValid,
	output fpWord_t  result,
	output fpFlags_t flags
);

	logic                        guardBit;
	logic                        roundBit;
	logic                        stickyBit;
	logic                        roundUp;
	logic [`FP_SIG_W:0]          rounded;  // Top bit is mantissa carry
	logic signed [`FP_EXP_W+1:0] finalExp;
	logic                        lostBits;

	assign guardBit  = norm.normSig[2];
	assign roundBit  = norm.normSig[1];
	assign stickyBit = norm.normSig[0];

	// Nearest even, ties go to even LSB
	assign roundUp = guardBit & (roundBit | stickyBit | norm.normSig[`FP_GRS_W]);

	assign rounded  = {1'b0, norm.normSig[`FP_EXT_W-1:`FP_GRS_W]}
	                + {{`FP_SIG_W{1'b0}}, roundUp};
	// On carry the mantissa field is all zero, only the exponent moves
	assign finalExp = norm.normExp + $signed({{(`FP_EXP_W+1){1'b0}}, rounded[`FP_SIG_W]});
	assign lostBits = |norm.normSig[`FP_GRS_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			result   <= '0;
			flags    <= '0;
		end else begin
			outValid <= norm.valid;
			flags    <= '0;
			if (norm.special) begin
				result        <= `FP_QNAN; // Any Inf/NaN operand
				flags.invalid <= 1'b1;
			end else if (norm.zero) begin
				result <= {norm.resSign, {(`FP_EXP_W+`FP_MAN_W){1'b0}}}; // Exact zero
			end else if (finalExp >= `FP_EXP_MAX) begin
				// Signed infinity
				result.sign    <= norm.resSign;
				result.exp     <= '1;
				result.man     <= '0;
				flags.overflow <= 1'b1;
				flags.inexact  <= 1'b1;
			end else if (norm.normExp < 1) begin
				// Below normal range, flush
				result          <= {norm.resSign, {(`FP_EXP_W+`FP_MAN_W){1'b0}}};
				flags.underflow <= 1'b1;
				flags.inexact   <= 1'b1;
			end else begin
				result.sign   <= norm.resSign;
				result.exp    <= finalExp[`FP_EXP_W-1:0];
				result.man    <= rounded[`FP_MAN_W-1:0];
				flags.inexact <= lostBits;
			end
		end
	end

endmodule

// ==== hw/fpAddSub.sv ====
`timescale 1ns/1ps
`include "fp16_config.svh"

module fpAddSub
	import fpAddPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     inValid,
	input  fpWord_t  a,
	input  fpWord_t  b,
	input  fpOp_e    op,
	output logic     outValid,
	output fpWord_t  result,
	output fpFlags_t flags
);

	// Stage boundaries, each one register deep
	unpackOut_t unpacked;
	alignOut_t  alignedOp;
	normOut_t   normed;

	// Classify, order by magnitude
	fpUnpack i_unpack (
		.clk     (clk),
		.rst     (rst),
		.inValid (inValid),
		.a       (a),
		.b       (b),
		.op      (op),
		.stage   (unpacked)
	);

	fpAlign i_align (
		.clk     (clk),
		.rst     (rst),
		.stage   (unpacked),
		.aligned (alignedOp)
	);

	fpNormalize i_normalize (
		.clk     (clk),
		.rst     (rst),
		.aligned (alignedOp),
		.norm    (normed)
	);

	// RNE, exceptions, output registers
	fpRound i_round (
		.clk      (clk),
		.rst      (rst),
		.norm     (normed),
		.outValid (outValid),
		.result   (result),
		.flags    (flags)
	);

endmodule

// ==== bench/tbFpAddSub.sv ====
`timescale 1ns/1ps

module tbFpAddSub
	import fpAddPkg::*;
();

	localparam int clkPeriod  = 20;
	localparam int latency    = 4;    // Drive cycle to outValid
	localparam int numRandom  = 2000;
	localparam int numCancel  = 50;   // Four ops each
	localparam int numRange   = 100;  // Two ops each
	localparam int numSpecial = 100;  // Two ops each
	localparam int numBurst   = 64;
	localparam int totalOps   = numRandom + 4 * numCancel + 4 + 2 * numRange
	                          + 2 * numSpecial + numBurst;
	localparam int watchdogCycles = totalOps * 20 + 100;

	logic     clk;
	logic     rst;
	logic     inValid;
	fpWord_t  a;
	fpWord_t  b;
	fpOp_e    op;
	logic     outValid;
	fpWord_t  result;
	fpFlags_t flags;

	logic [31:0] rngState = 32'd82;
	int          cycleCount = 0; // Rising edges seen
	fpWord_t     expWords[$];
	fpFlags_t    expFlags[$];
	int          expCycles[$];    // Cycle at which outValid is due

	fpAddSub i_dut (.*);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;
	always @(posedge clk) cycleCount <= cycleCount + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int randRange(input int lo, input int hi);
		rngState = xorshift32(rngState);
		return lo + int'(rngState % (hi - lo + 1));
	endfunction

	function automatic fpWord_t randWord(input int expLo, input int expHi);
		fpWord_t w;
		w.sign = 1'(randRange(0, 1));
		w.exp  = 5'(randRange(expLo, expHi));
		w.man  = 10'(randRange(0, 1023));
		return w;
	endfunction

	// Operand as an integer in units of 2^-24, subnormals flushed
	function automatic longint scaled(input fpWord_t w, input logic neg);
		longint mag;
		mag = (w.exp == 0) ? 0 : (longint'({1'b1, w.man}) << (w.exp - 1));
		return neg ? -mag : mag;
	endfunction

	// Exact sum, then RNE at 11 significant bits
	task automatic computeExpected(input fpWord_t x, input fpWord_t y, input fpOp_e o,
		output fpWord_t w, output fpFlags_t f);
		logic   sx;
		logic   sy;
		longint s;
		longint mag;
		longint q;
		longint rem;
		longint half;
		int     p;
		int     e;
		sx  = x.sign;
		sy  = y.sign ^ (o == opSub);
		s   = scaled(x, sx) + scaled(y, sy);
		mag = (s < 0) ? -s : s;
		p   = 0;
		for (int i = 0; i < 48; i++)
			if (mag[i])
				p = i;
		w = '0;
		f = '0;
		if (x.exp == 31 || y.exp == 31) begin
			w         = 16'h7E00; // Canonical NaN
			f.invalid = 1'b1;
		end else if (s == 0) begin
			w.sign = sx & sy;
		end else if (p < 10) begin // Below 2^-14
			w.sign      = (s < 0);
			f.underflow = 1'b1;
			f.inexact   = 1'b1;
		end else begin
			e    = p - 9;
			q    = mag >> (p - 10);
			rem  = mag - (q << (p - 10)); // Bits dropped below the LSB
			half = (p > 10) ? (longint'(1) << (p - 11)) : 0;
			if (p > 10 && (rem > half || (rem == half && q[0])))
				q = q + 1;
			if (q == 2048) begin // Rounded up past 11 bits
				q = 1024;
				e = e + 1;
			end
			w.sign    = (s < 0);
			f.inexact = (rem != 0);
			if (e >= 31) begin
				w.exp      = '1;
				f.overflow = 1'b1;
				f.inexact  = 1'b1;
			end else begin
				w.exp = 5'(e);
				w.man = q[9:0];
			end
		end
	endtask

	task automatic failRun(input string msg);
		$display("** Error [%0t ns] %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic checkWord(input fpWord_t got, input fpWord_t want);
		if (got !== want)
			failRun($sformatf("result %h, expected %h", got, want));
	endtask

	task automatic checkFlags(input fpFlags_t got, input fpFlags_t want);
		if (got !== want)
			failRun($sformatf("flags %b, expected %b", got, want));
	endtask

	task automatic checkCycle(input int got, input int want);
		if (got != want)
			failRun($sformatf("outValid in cycle %0d, expected cycle %0d", got, want));
	endtask

	task automatic issue(input fpWord_t x, input fpWord_t y, input fpOp_e o);
		fpWord_t  w;
		fpFlags_t f;
		@(negedge clk);
		inValid = 1'b1;
		a       = x;
		b       = y;
		op      = o;
		computeExpected(x, y, o, w, f);
		expWords.push_back(w);
		expFlags.push_back(f);
		expCycles.push_back(cycleCount + latency);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			inValid = 1'b0;
		end
	endtask

	// Outputs are registered, stable at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (outValid && expWords.size() == 0) begin
				failRun("outValid with no operation in flight");
			end else if (outValid) begin
				checkCycle(cycleCount, expCycles.pop_front());
				checkWord(result, expWords.pop_front());
				checkFlags(flags, expFlags.pop_front());
			end else if (expCycles.size() != 0 && expCycles[0] <= cycleCount) begin
				failRun("outValid missing for an accepted operation");
			end
		end
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Run did not finish within %0d cycles", watchdogCycles);
		$display("sim failed");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		fpWord_t x;
		fpWord_t y;
		int      ye;
		rst     = 1'b1;
		inValid = 1'b0;
		a       = '0;
		b       = '0;
		op      = opAdd;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle(5); // Quiet after reset
		for (int i = 0; i < numRandom; i++) begin
			x  = randWord(1, 30);
			ye = int'(x.exp) + randRange(-20, 20); // Wide spread for sticky
			ye = (ye < 1) ? 1 : ((ye > 30) ? 30 : ye);
			y  = randWord(ye, ye);
			issue(x, y, fpOp_e'(randRange(0, 1)));
			if (randRange(0, 7) == 0)
				idle(randRange(1, 3));
		end
		for (int i = 0; i < numCancel; i++) begin
			x      = randWord(1, 30);
			y      = x;
			y.sign = ~x.sign;
			issue(x, x, opSub);
			issue(y, x, opAdd);
			issue(y, y, opSub);
			x     = randWord(12, 30);
			y     = x;
			y.man = x.man ^ 10'(1 << randRange(0, 3)); // Near-equal, deep shift
			issue(x, y, opSub);
		end
		issue(16'h8000, 16'h8000, opAdd); // Both negative zero
		issue(16'h8000, 16'h0000, opSub);
		issue(16'h0000, 16'h0000, opSub);
		issue(16'h8123, 16'h8045, opAdd); // Negative subnormals
		for (int i = 0; i < numRange; i++) begin
			x      = randWord(29, 30);
			y      = randWord(29, 30);
			y.sign = x.sign;
			issue(x, y, opAdd);
			x = randWord(1, 1);
			y = randWord(1, 2);
			issue(x, y, (x.sign == y.sign) ? opSub : opAdd); // Tiny difference
		end
		for (int i = 0; i < numSpecial; i++) begin
			x = randWord(31, 31); // Inf or NaN
			y = randWord(0, 30);
			if (randRange(0, 1) == 1)
				issue(x, y, fpOp_e'(randRange(0, 1)));
			else
				issue(y, x, fpOp_e'(randRange(0, 1)));
			issue(randWord(0, 0), randWord(0, 30), fpOp_e'(randRange(0, 1)));
		end
		idle(8);
		for (int i = 0; i < numBurst; i++)
			issue(randWord(1, 30), randWord(1, 30), fpOp_e'(randRange(0, 1)));
		idle(10); // Drain, no stray outValid
		if (expWords.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("Run ended with %0d results never seen", expWords.size());
			$display("sim failed");
			$fatal(1, "results missing");
		end
	end

endmodule

// ==== project.f ====
+incdir+include
hw/fpAddPkg.sv
hw/fpUnpack.sv
hw/fpAlign.sv
hw/fpNormalize.sv
hw/fpRound.sv
hw/fpAddSub.sv
bench/tbFpAddSub.sv

// ==== Bender.yml ====
package:
  name: fp_add_sub

sources:
  - include_dirs:
      - include
    files:
      - hw/fpAddPkg.sv
      - hw/fpUnpack.sv
      - hw/fpAlign.sv
      - hw/fpNormalize.sv
      - hw/fpRound.sv
      - hw/fpAddSub.sv
  - target: simulation
    files:
      - bench/tbFpAddSub.sv
